// ==== hdl/apb_host_port.sv ====
module apb_host_port (
	input logic CLK,
	input logic RST,
	input logic [sdram_pkg::APB_ADDR_W-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [sdram_pkg::DATA_W-1:0] pwdata,
	input logic done,
	input logic [sdram_pkg::DATA_W-1:0] rdata,
	input logic rdata_valid,
	output logic [sdram_pkg::DATA_W-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic do_act,
	output logic [sdram_pkg::ADDR_W-1:0] word_addr,
	output logic we,
	output logic [sdram_pkg::DATA_W-1:0] wdata
);
	logic [sdram_pkg::DATA_W-1:0] rdata_reg;
	logic busy;
	logic rd_valid;
	logic access;
	logic mapped;
	logic start;

	assign access = psel && penable;
	assign mapped = (paddr == sdram_pkg::REG_ADDR) || (paddr == sdram_pkg::REG_WDATA) ||
		(paddr == sdram_pkg::REG_CTRL) || (paddr == sdram_pkg::REG_RDATA);
	assign start = access && pwrite && (paddr == sdram_pkg::REG_CTRL) && pwdata[0];
	assign pready = 1'b1;	// zero wait states
	assign pslverr = access && (!mapped || (start && busy));

	always_comb
	begin
		case (paddr)
			sdram_pkg::REG_ADDR: prdata = {{(sdram_pkg::DATA_W - sdram_pkg::ADDR_W){1'b0}}, word_addr};
			sdram_pkg::REG_WDATA: prdata = wdata;
			sdram_pkg::REG_CTRL: prdata = {{(sdram_pkg::DATA_W - 2){1'b0}}, rd_valid, busy};
			sdram_pkg::REG_RDATA: prdata = rdata_reg;
			default: prdata = '0;
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			busy <= 1'b0;
			rd_valid <= 1'b0;
			do_act <= 1'b0;
			we <= 1'b0;
		end
		else
		begin
			do_act <= 1'b0;
			if (start && !busy)
			begin
				busy <= 1'b1;
				we <= pwdata[1];
				do_act <= 1'b1;
				rd_valid <= 1'b0;
			end
			else if (busy && ((done && we) || rdata_valid))
				busy <= 1'b0;	// write ends at issue, read at data return
			if (rdata_valid)
				rd_valid <= 1'b1;
		end
	end

	// request fields are frozen while a transaction runs
	always_ff @(posedge CLK)
	begin
		if (access && pwrite && !busy)
		begin
			if (paddr == sdram_pkg::REG_ADDR)
				word_addr <= pwdata[sdram_pkg::ADDR_W-1:0];
			if (paddr == sdram_pkg::REG_WDATA)
				wdata <= pwdata;
		end
		if (rdata_valid)
			rdata_reg <= rdata;
	end

endmodule

// ==== hdl/bank_timer.sv ====
module bank_timer (
	input logic CLK,
	input logic RST,
	input logic change_req,
	input sdram_pkg::sdram_cmd_e cmd_next,
	output logic change_ok,
	output logic page_open
);
	sdram_pkg::sdram_cmd_e state;
	logic [sdram_pkg::CNT_W-1:0] count;
	logic state_rw;
	logic repeat_rw;
	logic accept;
	int unsigned wait_len;

	assign repeat_rw = state_rw && (cmd_next == state);
	assign change_ok = (count == '0) || repeat_rw;
	assign accept = change_req && change_ok;

	// cycles to hold off after the command, less the one already spent
	always_comb
	begin
		case (cmd_next)
			sdram_pkg::CMD_PRCH: wait_len = sdram_pkg::T_RP - 1;
			sdram_pkg::CMD_ACTV: wait_len = sdram_pkg::T_RCD - 1;
			sdram_pkg::CMD_READ, sdram_pkg::CMD_WRTE: wait_len = sdram_pkg::T_RW - 1;
			sdram_pkg::CMD_ARSR: wait_len = sdram_pkg::T_RFC - 1;
			default: wait_len = 0;
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			state <= sdram_pkg::CMD_PRCH;
			state_rw <= 1'b0;
			count <= '0;	// terminal count
			page_open <= 1'b0;
		end
		else if (accept)
		begin
			state <= cmd_next;
			state_rw <= (cmd_next == sdram_pkg::CMD_READ) || (cmd_next == sdram_pkg::CMD_WRTE);
			count <= wait_len[sdram_pkg::CNT_W-1:0];
			if (cmd_next == sdram_pkg::CMD_ACTV)
				page_open <= 1'b1;
			else if (cmd_next == sdram_pkg::CMD_PRCH)
				page_open <= 1'b0;	// precharge closes every bank
		end
		else if (count != '0)
			count <= count - 1'b1;
	end

endmodule

// ==== hdl/command_sequencer.sv ====
module command_sequencer (
	input logic CLK,
	input logic RST,
	input logic do_act,
	input logic [sdram_pkg::ADDR_W-1:0] word_addr,
	input logic we,
	input logic change_ok,
	input logic page_open,
	output sdram_pkg::sdram_cmd_e cmd_next,
	output logic change_req,
	output sdram_pkg::sdram_cmd_e sd_cmd,
	output logic [sdram_pkg::ROW_W-1:0] sd_addr,
	output logic [sdram_pkg::BANK_W-1:0] sd_ba,
	output logic issue,
	output logic done
);
	sdram_pkg::sdram_cmd_e seq [3];
	sdram_pkg::sdram_cmd_e rw_cmd;
	logic [1:0] pending;
	logic req_wait;
	logic [sdram_pkg::ROW_W+sdram_pkg::BANK_W-1:0] page_cur;
	logic [sdram_pkg::REF_CNT_W-1:0] ref_cnt;
	logic ref_due;
	logic [sdram_pkg::ROW_W-1:0] row;
	logic [sdram_pkg::BANK_W-1:0] bank;
	logic [sdram_pkg::COL_W-1:0] col;
	logic accept;
	logic page_hit;

	assign row = word_addr[sdram_pkg::ADDR_W-1 -: sdram_pkg::ROW_W];
	assign bank = word_addr[sdram_pkg::COL_W +: sdram_pkg::BANK_W];
	assign col = word_addr[sdram_pkg::COL_W-1:0];
	assign rw_cmd = we ? sdram_pkg::CMD_WRTE : sdram_pkg::CMD_READ;
	assign cmd_next = seq[0];
	assign change_req = (pending != 2'd0);
	assign accept = change_req && change_ok;
	assign page_hit = page_open && ({row, bank} == page_cur);
	assign done = issue;	// read or write on the pins

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			seq[0] <= sdram_pkg::CMD_NOOP;
			seq[1] <= sdram_pkg::CMD_NOOP;
			seq[2] <= sdram_pkg::CMD_NOOP;
			pending <= 2'd0;
			req_wait <= 1'b0;
			page_cur <= '0;
			ref_cnt <= '0;
			ref_due <= 1'b0;
			sd_cmd <= sdram_pkg::CMD_NOOP;
			sd_addr <= '0;
			sd_ba <= '0;
			issue <= 1'b0;
		end
		else
		begin
			issue <= 1'b0;
			sd_cmd <= sdram_pkg::CMD_NOOP;
			if (do_act)
				req_wait <= 1'b1;	// held until the sequence is loaded

			if (accept)
			begin
				seq[0] <= seq[1];
				seq[1] <= seq[2];
				seq[2] <= sdram_pkg::CMD_NOOP;
				pending <= pending - 2'd1;
				sd_cmd <= seq[0];
				case (seq[0])
					sdram_pkg::CMD_ACTV:
					begin
						sd_addr <= row;
						sd_ba <= bank;
						page_cur <= {row, bank};
					end
					sdram_pkg::CMD_READ, sdram_pkg::CMD_WRTE:
					begin
						sd_addr <= col;
						sd_ba <= bank;
						issue <= 1'b1;
					end
					sdram_pkg::CMD_PRCH:
					begin
						sd_addr <= '0;
						sd_addr[sdram_pkg::PRCH_ALL_BIT] <= 1'b1;	// all banks
					end
					default: ;
				endcase
			end
			else if (!change_req)
			begin
				if (ref_due)
				begin
					seq[0] <= sdram_pkg::CMD_PRCH;
					seq[1] <= sdram_pkg::CMD_ARSR;
					seq[2] <= sdram_pkg::CMD_NOOP;
					pending <= 2'd2;
					ref_due <= 1'b0;
				end
				else if (do_act || req_wait)
				begin
					req_wait <= 1'b0;
					if (page_hit)
					begin
						seq[0] <= rw_cmd;
						seq[1] <= sdram_pkg::CMD_NOOP;
						seq[2] <= sdram_pkg::CMD_NOOP;
						pending <= 2'd1;
					end
					else
					begin
						seq[0] <= sdram_pkg::CMD_PRCH;
						seq[1] <= sdram_pkg::CMD_ACTV;
						seq[2] <= rw_cmd;
						pending <= 2'd3;
					end
				end
			end

			if (ref_cnt == sdram_pkg::REFRESH_INTERVAL - 1)
			begin
				ref_cnt <= '0;
				ref_due <= 1'b1;
			end
			else
				ref_cnt <= ref_cnt + 1'b1;
		end
	end

endmodule

// ==== hdl/data_path.sv ====
module data_path (
	input logic CLK,
	input logic RST,
	input logic issue,
	input logic we,
	input logic [sdram_pkg::DATA_W-1:0] wdata,
	input logic [sdram_pkg::DATA_W-1:0] sd_dq_in,
	output logic [sdram_pkg::DATA_W-1:0] sd_dq_out,
	output logic sd_dq_oe,
	output logic [sdram_pkg::DATA_W-1:0] rdata,
	output logic rdata_valid
);
	logic [sdram_pkg::CAS_LATENCY-1:0] rd_pipe;
	logic rd_issue;

	assign rd_issue = issue && !we;
	assign sd_dq_oe = issue && we;	// same cycle as WRTE on the pins
	assign sd_dq_out = sd_dq_oe ? wdata : '0;

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			rd_pipe <= '0;
			rdata_valid <= 1'b0;
		end
		else
		begin
			rd_pipe <= {rd_pipe[sdram_pkg::CAS_LATENCY-2:0], rd_issue};
			rdata_valid <= rd_pipe[sdram_pkg::CAS_LATENCY-1];
		end
	end

	// sample at the end of the CAS latency window
	always_ff @(posedge CLK)
	begin
		if (rd_pipe[sdram_pkg::CAS_LATENCY-1])
			rdata <= sd_dq_in;
	end

endmodule

// ==== hdl/sdram_ctrl_top.sv ====
module sdram_ctrl_top (
	input logic CLK,
	input logic RST,
	input logic [sdram_pkg::APB_ADDR_W-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [sdram_pkg::DATA_W-1:0] pwdata,
	input logic [sdram_pkg::DATA_W-1:0] sd_dq_in,
	output logic [sdram_pkg::DATA_W-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output sdram_pkg::sdram_cmd_e sd_cmd,
	output logic [sdram_pkg::ROW_W-1:0] sd_addr,
	output logic [sdram_pkg::BANK_W-1:0] sd_ba,
	output logic [sdram_pkg::DATA_W-1:0] sd_dq_out,
	output logic sd_dq_oe
);
	logic do_act;
	logic done;
	logic we;
	logic issue;
	logic change_req;
	logic change_ok;
	logic page_open;
	logic rdata_valid;
	logic [sdram_pkg::ADDR_W-1:0] word_addr;
	logic [sdram_pkg::DATA_W-1:0] wdata;
	logic [sdram_pkg::DATA_W-1:0] rdata;
	sdram_pkg::sdram_cmd_e cmd_next;

	apb_host_port apb_i (
		.CLK(CLK), .RST(RST), .paddr(paddr), .psel(psel), .penable(penable),
		.pwrite(pwrite), .pwdata(pwdata), .done(done), .rdata(rdata),
		.rdata_valid(rdata_valid), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.do_act(do_act), .word_addr(word_addr), .we(we), .wdata(wdata)
	);

	command_sequencer seq_i (
		.CLK(CLK), .RST(RST), .do_act(do_act), .word_addr(word_addr), .we(we),
		.change_ok(change_ok), .page_open(page_open), .cmd_next(cmd_next),
		.change_req(change_req), .sd_cmd(sd_cmd), .sd_addr(sd_addr), .sd_ba(sd_ba),
		.issue(issue), .done(done)
	);

	bank_timer timer_i (
		.CLK(CLK), .RST(RST), .change_req(change_req), .cmd_next(cmd_next),
		.change_ok(change_ok), .page_open(page_open)
	);

	data_path dpath_i (
		.CLK(CLK), .RST(RST), .issue(issue), .we(we), .wdata(wdata), .sd_dq_in(sd_dq_in),
		.sd_dq_out(sd_dq_out), .sd_dq_oe(sd_dq_oe), .rdata(rdata), .rdata_valid(rdata_valid)
	);

endmodule

// ==== hdl/sdram_pkg.sv ====
package sdram_pkg;

	// encoded as {ras_n, cas_n, we_n}
	typedef enum logic [2:0] {
		CMD_NOOP = 3'b111,
		CMD_ACTV = 3'b011,
		CMD_READ = 3'b101,
		CMD_WRTE = 3'b100,
		CMD_PRCH = 3'b010,
		CMD_ARSR = 3'b001
	} sdram_cmd_e;

	localparam int ROW_W = 13;
	localparam int BANK_W = 2;
	localparam int COL_W = 13;
	localparam int ADDR_W = 28;	// row, bank, column from the top
	localparam int DATA_W = 32;

	localparam int T_RP = 3;
	localparam int T_RCD = 2;
	localparam int T_RW = 3;
	localparam int T_RFC = 15;
	localparam int CAS_LATENCY = 2;
	localparam int REFRESH_INTERVAL = 390;
	localparam int PRCH_ALL_BIT = 10;

	localparam int CNT_W = 4;	// wide enough for T_RFC - 1
	localparam int REF_CNT_W = 9;

	localparam int APB_ADDR_W = 8;
	localparam logic [APB_ADDR_W-1:0] REG_ADDR = 8'h00;
	localparam logic [APB_ADDR_W-1:0] REG_WDATA = 8'h04;
	localparam logic [APB_ADDR_W-1:0] REG_CTRL = 8'h08;	// wr: start, we / rd: busy, valid
	localparam logic [APB_ADDR_W-1:0] REG_RDATA = 8'h0c;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# build and run the SDRAM controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module sdram_ctrl_tb \
	-f sdram_ctrl.f -o sdram_ctrl_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/sdram_ctrl_sim > sim.log 2>&1
sim_status=$?

if grep -q "RESULT: FAIL" sim.log; then
	echo "simulation reported failure, see sim.log"
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "simulator exited with status $sim_status, see sim.log"
	exit 1
fi
echo "simulation passed"
exit 0

// ==== sdram_ctrl.f ====
hdl/sdram_pkg.sv
hdl/apb_host_port.sv
hdl/command_sequencer.sv
hdl/bank_timer.sv
hdl/data_path.sv
hdl/sdram_ctrl_top.sv
tb/sdram_model.sv
tb/sdram_ctrl_assertions.sv
tb/sdram_ctrl_tb.sv

// ==== tb/sdram_ctrl_assertions.sv ====
module sdram_ctrl_assertions (
	input logic CLK,
	input logic RST,
	input logic change_req,
	input logic change_ok,
	input logic page_open,
	input sdram_pkg::sdram_cmd_e cmd_next
);
	timeunit 1ns;
	timeprecision 100ps;

	logic accept;
	logic rw_repeat;
	sdram_pkg::sdram_cmd_e last_cmd;
	int unsigned since;
	int unsigned min_gap;

	assign accept = change_req && change_ok;
	assign rw_repeat = (cmd_next == last_cmd) &&
		((last_cmd == sdram_pkg::CMD_READ) || (last_cmd == sdram_pkg::CMD_WRTE));

	// spacing the last accepted command needs
	always_comb
	begin
		case (last_cmd)
			sdram_pkg::CMD_PRCH: min_gap = sdram_pkg::T_RP;
			sdram_pkg::CMD_ACTV: min_gap = sdram_pkg::T_RCD;
			sdram_pkg::CMD_READ, sdram_pkg::CMD_WRTE: min_gap = sdram_pkg::T_RW;
			sdram_pkg::CMD_ARSR: min_gap = sdram_pkg::T_RFC;
			default: min_gap = 0;
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			last_cmd <= sdram_pkg::CMD_NOOP;
			since <= 0;
		end
		else if (accept)
		begin
			last_cmd <= cmd_next;
			since <= 1;
		end
		else if (since < sdram_pkg::T_RFC)
			since <= since + 1;	// saturates at the longest wait
	end

	wait_respected: assert property (@(posedge CLK) disable iff (!RST)
		accept |-> (since >= min_gap || rw_repeat))
		else $error("command accepted before its wait ran out");

	actv_closed_page: assert property (@(posedge CLK) disable iff (!RST)
		(accept && cmd_next == sdram_pkg::CMD_ACTV) |-> !page_open)
		else $error("activate accepted with a page open");

	prch_closes: assert property (@(posedge CLK) disable iff (!RST)
		(accept && cmd_next == sdram_pkg::CMD_PRCH) |=> !page_open)
		else $error("page still open after precharge");

endmodule

bind bank_timer sdram_ctrl_assertions timer_asrt_i (
	.CLK(CLK), .RST(RST), .change_req(change_req), .change_ok(change_ok),
	.page_open(page_open), .cmd_next(cmd_next)
);

// ==== tb/sdram_ctrl_tb.sv ====
module sdram_ctrl_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_TXN = 26;
	localparam int TXN_CYCLES = 2 * (sdram_pkg::T_RP + sdram_pkg::T_RCD + sdram_pkg::T_RFC +
		sdram_pkg::CAS_LATENCY + 20);	// doubled for the APB accesses around it
	localparam int IDLE_CYCLES = 2 * sdram_pkg::REFRESH_INTERVAL + 20;
	localparam int CYCLE_LIMIT = NUM_TXN * TXN_CYCLES + 2 * IDLE_CYCLES + 500;
	localparam int REFRESH_GAP = sdram_pkg::REFRESH_INTERVAL + TXN_CYCLES / 2;

	logic CLK;
	logic RST;
	logic [sdram_pkg::APB_ADDR_W-1:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [sdram_pkg::DATA_W-1:0] pwdata;
	logic [sdram_pkg::DATA_W-1:0] prdata;
	logic pready;
	logic pslverr;
	sdram_pkg::sdram_cmd_e sd_cmd;
	logic [sdram_pkg::ROW_W-1:0] sd_addr;
	logic [sdram_pkg::BANK_W-1:0] sd_ba;
	logic [sdram_pkg::DATA_W-1:0] sd_dq_out;
	logic [sdram_pkg::DATA_W-1:0] sd_dq_in;
	logic sd_dq_oe;

	logic [31:0] lfsr = 32'hf9c95f14;
	logic [sdram_pkg::DATA_W-1:0] ref_mem [logic [sdram_pkg::ADDR_W-1:0]];
	logic page_valid = 1'b0;
	logic [sdram_pkg::ROW_W+sdram_pkg::BANK_W-1:0] open_page;
	int cycles = 0;
	int actv_cnt = 0;
	int arsr_cnt = 0;
	int rw_cnt = 0;
	int rw_arsr = 0;
	int prev_rw_arsr = 0;
	int gap = 0;
	logic last_refreshed;
	sdram_pkg::sdram_cmd_e hist1 = sdram_pkg::CMD_NOOP;
	sdram_pkg::sdram_cmd_e hist2 = sdram_pkg::CMD_NOOP;
	sdram_pkg::sdram_cmd_e rw_prev1;
	sdram_pkg::sdram_cmd_e rw_prev2;
	sdram_pkg::sdram_cmd_e rw_seen;
	sdram_pkg::sdram_cmd_e last_rw = sdram_pkg::CMD_NOOP;

	sdram_ctrl_top dut_i (
		.CLK(CLK), .RST(RST), .paddr(paddr), .psel(psel), .penable(penable),
		.pwrite(pwrite), .pwdata(pwdata), .sd_dq_in(sd_dq_in), .prdata(prdata),
		.pready(pready), .pslverr(pslverr), .sd_cmd(sd_cmd), .sd_addr(sd_addr),
		.sd_ba(sd_ba), .sd_dq_out(sd_dq_out), .sd_dq_oe(sd_dq_oe)
	);

	sdram_model mem_i (
		.CLK(CLK), .sd_cmd(sd_cmd), .sd_addr(sd_addr), .sd_ba(sd_ba),
		.sd_dq_out(sd_dq_out), .sd_dq_oe(sd_dq_oe), .sd_dq_in(sd_dq_in)
	);

	initial
	begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	task automatic stop_on_error();
		$display("RESULT: FAIL");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_data(input string name, input logic [sdram_pkg::DATA_W-1:0] got,
		input logic [sdram_pkg::DATA_W-1:0] exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_cmd(input string name, input sdram_pkg::sdram_cmd_e got,
		input sdram_pkg::sdram_cmd_e exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
			stop_on_error();
		end
	endtask

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// expected memory contents and open page
	function automatic void ref_write(input logic [27:0] a, input logic [31:0] d);
		ref_mem[a] = d;
	endfunction

	function automatic logic [31:0] ref_read(input logic [27:0] a);
		return ref_mem.exists(a) ? ref_mem[a] : 32'hxxxx_xxxx;
	endfunction

	// one page open at a time, a miss precharges all banks
	function automatic logic predict_miss(input logic [27:0] a, input logic refreshed);
		logic miss;
		miss = !page_valid || refreshed || (a[27:13] != open_page);
		page_valid = 1'b1;
		open_page = a[27:13];
		return miss;
	endfunction

	task automatic apb_write(input logic [7:0] a, input logic [31:0] d, output logic err);
		@(posedge CLK);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = a;
		pwdata = d;
		@(posedge CLK);
		#1;
		penable = 1'b1;
		@(negedge CLK);
		check_flag("pready", pready, 1'b1);
		err = pslverr;
		@(posedge CLK);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] a, output logic [31:0] d, output logic err);
		@(posedge CLK);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = a;
		@(posedge CLK);
		#1;
		penable = 1'b1;
		@(negedge CLK);
		check_flag("pready", pready, 1'b1);
		d = prdata;
		err = pslverr;
		@(posedge CLK);
		#1;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic wait_idle(output logic [31:0] ctrl);
		logic err;
		do
			apb_read(sdram_pkg::REG_CTRL, ctrl, err);
		while (ctrl[0]);
	endtask

	task automatic run_txn(input logic [27:0] a, input logic wr, input logic [31:0] d,
		input logic refuse);
		logic err;
		logic miss;
		logic [31:0] ctrl;
		logic [31:0] rd;
		int actv0;
		int rw0;
		sdram_pkg::sdram_cmd_e rw_exp;
		rw_exp = wr ? sdram_pkg::CMD_WRTE : sdram_pkg::CMD_READ;
		apb_write(sdram_pkg::REG_ADDR, {4'h0, a}, err);
		check_flag("pslverr", err, 1'b0);
		if (wr)
		begin
			apb_write(sdram_pkg::REG_WDATA, d, err);
			check_flag("pslverr", err, 1'b0);
		end
		actv0 = actv_cnt;
		rw0 = rw_cnt;
		apb_write(sdram_pkg::REG_CTRL, {30'd0, wr, 1'b1}, err);
		check_flag("pslverr", err, 1'b0);
		if (refuse)
		begin
			apb_write(sdram_pkg::REG_CTRL, 32'h1, err);
			check_flag("pslverr on start while busy", err, 1'b1);
		end
		wait_idle(ctrl);
		last_refreshed = (rw_arsr != prev_rw_arsr);
		prev_rw_arsr = rw_arsr;
		miss = predict_miss(a, last_refreshed);
		check_data("rw count", rw_cnt - rw0, 32'd1);
		check_cmd("sd_cmd", rw_seen, rw_exp);
		check_data("actv count", actv_cnt - actv0, {31'd0, miss});
		if (miss)
		begin
			check_cmd("sd_cmd before rw", rw_prev1, sdram_pkg::CMD_ACTV);
			check_cmd("sd_cmd before actv", rw_prev2, sdram_pkg::CMD_PRCH);
		end
		else
			check_cmd("sd_cmd before rw", rw_prev1, last_rw);
		last_rw = rw_exp;
		if (wr)
			ref_write(a, d);
		else
		begin
			check_flag("rd_valid", ctrl[1], 1'b1);
			apb_read(sdram_pkg::REG_RDATA, rd, err);
			check_data("rdata", rd, ref_read(a));
		end
	endtask

	// command monitor with refresh spacing
	always @(negedge CLK)
	begin
		if (RST)
		begin
			check_flag("sd_dq_oe", sd_dq_oe, sd_cmd == sdram_pkg::CMD_WRTE);
			gap++;
			if (gap > REFRESH_GAP)
			begin
				$display("no auto refresh within %0d cycles", REFRESH_GAP);
				stop_on_error();
			end
			case (sd_cmd)
				sdram_pkg::CMD_ACTV: actv_cnt++;
				sdram_pkg::CMD_PRCH:
					check_flag("sd_addr[PRCH_ALL_BIT]", sd_addr[sdram_pkg::PRCH_ALL_BIT], 1'b1);
				sdram_pkg::CMD_ARSR:
				begin
					arsr_cnt++;
					gap = 0;
				end
				sdram_pkg::CMD_READ, sdram_pkg::CMD_WRTE:
				begin
					rw_cnt++;
					rw_arsr = arsr_cnt;
					rw_prev1 = hist1;
					rw_prev2 = hist2;
					rw_seen = sd_cmd;
				end
				default: ;
			endcase
			if (sd_cmd != sdram_pkg::CMD_NOOP)
			begin
				hist2 = hist1;
				hist1 = sd_cmd;
			end
		end
	end

	always @(posedge CLK)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout after %0d cycles", cycles);
			stop_on_error();
		end
	end

	initial
	begin
		logic [27:0] addrs [8];
		logic [27:0] base;
		logic [sdram_pkg::COL_W-1:0] col;
		logic [31:0] d;
		logic err;
		RST = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (10) @(posedge CLK);
		#1;
		RST = 1'b1;

		apb_read(sdram_pkg::REG_CTRL, d, err);
		check_flag("busy after reset", d[0], 1'b0);
		check_flag("rd_valid after reset", d[1], 1'b0);

		for (int i = 0; i < 8; i++)
		begin
			addrs[i] = rand_bits(28);
			run_txn(addrs[i], 1'b1, rand_bits(32), 1'b0);
		end
		for (int i = 0; i < 8; i++)
			run_txn(addrs[i], 1'b0, '0, 1'b0);

		base = rand_bits(28);
		run_txn(base, 1'b1, rand_bits(32), 1'b0);
		col = rand_bits(13);
		run_txn({base[27:13], col}, 1'b1, rand_bits(32), 1'b0);	// same page
		run_txn(base, 1'b0, '0, 1'b0);
		run_txn({base[27:15] + 13'd1, base[14:0]}, 1'b1, rand_bits(32), 1'b0);	// new row
		run_txn({base[27:15] + 13'd1, base[14:0]}, 1'b0, '0, 1'b0);
		run_txn(base, 1'b0, '0, 1'b0);

		repeat (IDLE_CYCLES) @(posedge CLK);
		check_flag("refresh seen", arsr_cnt > 0, 1'b1);
		run_txn(base, 1'b0, '0, 1'b0);
		check_flag("refresh before access", last_refreshed, 1'b1);

		base = rand_bits(28);
		run_txn(base, 1'b1, rand_bits(32), 1'b1);
		run_txn(base, 1'b0, '0, 1'b0);
		apb_read(8'h10, d, err);
		check_data("prdata unmapped", d, 32'h0);
		check_flag("pslverr unmapped", err, 1'b1);

		repeat (IDLE_CYCLES) @(posedge CLK);
		run_txn(addrs[0], 1'b0, '0, 1'b0);

		$display("RESULT: PASS");
		$finish;
	end

endmodule

// ==== tb/sdram_model.sv ====
module sdram_model (
	input logic CLK,
	input sdram_pkg::sdram_cmd_e sd_cmd,
	input logic [sdram_pkg::ROW_W-1:0] sd_addr,
	input logic [sdram_pkg::BANK_W-1:0] sd_ba,
	input logic [sdram_pkg::DATA_W-1:0] sd_dq_out,
	input logic sd_dq_oe,
	output logic [sdram_pkg::DATA_W-1:0] sd_dq_in
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [sdram_pkg::ROW_W-1:0] open_row [4];
	logic row_open [4];
	logic [sdram_pkg::DATA_W-1:0] mem [logic [sdram_pkg::ADDR_W-1:0]];
	logic [sdram_pkg::DATA_W-1:0] rd_stage [sdram_pkg::CAS_LATENCY-1];

	initial
	begin
		sd_dq_in = '0;
		for (int i = 0; i < 4; i++)
			row_open[i] = 1'b0;
	end

	always @(posedge CLK)
	begin
		logic [sdram_pkg::ADDR_W-1:0] a;
		a = {open_row[sd_ba], sd_ba, sd_addr};
		case (sd_cmd)
			sdram_pkg::CMD_ACTV:
			begin
				open_row[sd_ba] <= sd_addr;
				row_open[sd_ba] <= 1'b1;
			end
			sdram_pkg::CMD_PRCH:
			begin
				for (int i = 0; i < 4; i++)
					if (sd_addr[sdram_pkg::PRCH_ALL_BIT] || sd_ba == i)
						row_open[i] <= 1'b0;
			end
			sdram_pkg::CMD_WRTE:
				if (sd_dq_oe && row_open[sd_ba])
					mem[a] = sd_dq_out;
			sdram_pkg::CMD_READ:
				if (!row_open[sd_ba])
					rd_stage[0] <= 32'hdead_beef;	// closed bank
				else if (mem.exists(a))
					rd_stage[0] <= mem[a];
				else
					rd_stage[0] <= 32'h0bad_0bad;
			default: ;
		endcase
		for (int i = 1; i < sdram_pkg::CAS_LATENCY - 1; i++)
			rd_stage[i] <= rd_stage[i-1];
		sd_dq_in <= rd_stage[sdram_pkg::CAS_LATENCY-2];
	end

endmodule
